// File: source/l2_axi_pkg.sv
/* shared types for the L2 cache to AXI3 bridge; referenced by scoped name
   from the channel FSMs, the data path and the top level */
package l2_axi_pkg;

    localparam logic [1:0] BURST_INCR = 2'b01; // only burst type issued

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e; // error when bit 1 set

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    // cache side
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;  // beats minus one
        logic [2:0]  size;
    } burst_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } wr_beat_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
        logic        err;
    } rd_beat_t;

    // AXI side
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

endpackage

// File: source/l2_axi_beat_counter.sv
/* remaining-beat counter of one burst, loaded on the address handshake
   and decremented per accepted beat; is_last is high while it reads zero */
`timescale 1ns/10ps

module l2_axi_beat_counter #(
    parameter int CNT_W = 8
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             load,
    input  logic [CNT_W-1:0] len,
    input  logic             beat,
    output logic             is_last,
    output logic [CNT_W-1:0] count
);

    logic armed; // a burst is in flight

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
            armed <= 1'b0;
        end else if (load) begin
            count <= len;
            armed <= 1'b1;
        end else if (beat) begin
            if (count == '0) begin
                armed <= 1'b0; // final beat taken
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign is_last = (count == '0);

    // once the final beat is consumed no more may come until the next load
    a_beat_in_burst: assert property (
        @(posedge clk) disable iff (!rstn)
        beat |-> (armed || load)
    ) else $error("beat accepted past the end of the burst");

endmodule

// File: source/l2_axi_rdata_path.sv
/* read beat register; flags slave errors and rlast mismatches, then
   returns the fill word with err set until the burst ends */
`timescale 1ns/10ps

module l2_axi_rdata_path #(
    parameter logic [31:0] FILL_WORD = 32'hABCD1234
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  capture,      // R handshake
    input  logic                  start,        // AR handshake
    input  l2_axi_pkg::axi_r_t    r,
    input  logic                  counted_last,
    output logic                  rd_beat_valid,
    output l2_axi_pkg::rd_beat_t  rd_beat
);

    logic err_sticky;
    logic beat_err;
    logic err_now;

    // SLVERR/DECERR, or slave rlast disagreeing with our own count
    assign beat_err = r.resp[1] || (r.last != counted_last);
    assign err_now  = err_sticky || beat_err;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_beat_valid <= 1'b0;
            err_sticky    <= 1'b0;
        end else begin
            rd_beat_valid <= capture;
            if (start) begin
                err_sticky <= 1'b0;
            end else if (capture && beat_err) begin
                err_sticky <= 1'b1; // held to end of burst
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rd_beat.data <= err_now ? FILL_WORD : r.data;
            rd_beat.last <= counted_last;
            rd_beat.err  <= err_now;
        end
    end

endmodule

// File: source/l2_axi_read_fsm.sv
/* read channel: issues one AR burst per cache request and returns each
   R beat to the cache through the beat counter and read data path */
`timescale 1ns/10ps

module l2_axi_read_fsm #(
    parameter logic [31:0] FILL_WORD = 32'hABCD1234,
    parameter int          CNT_W     = 8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   rd_req_valid,
    input  l2_axi_pkg::burst_req_t rd_req,
    input  logic                   ar_ready,
    input  logic                   r_valid,
    input  l2_axi_pkg::axi_r_t     r,
    output logic                   rd_addr_ok,
    output logic                   ar_valid,
    output l2_axi_pkg::axi_addr_t  ar,
    output logic                   r_ready,
    output logic                   rd_beat_valid,
    output l2_axi_pkg::rd_beat_t   rd_beat
);

    l2_axi_pkg::rd_state_e state;
    l2_axi_pkg::rd_state_e state_nxt;
    logic                  ar_hs;
    logic                  r_hs;
    logic                  is_last;
    logic [CNT_W-1:0]      burst_len;

    assign ar_hs     = ar_valid && ar_ready;
    assign r_hs      = r_valid && r_ready;
    assign burst_len = CNT_W'(rd_req.len);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= l2_axi_pkg::RD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            l2_axi_pkg::RD_IDLE: if (rd_req_valid) state_nxt = l2_axi_pkg::RD_ADDR;
            l2_axi_pkg::RD_ADDR: if (ar_ready) state_nxt = l2_axi_pkg::RD_DATA;
            l2_axi_pkg::RD_DATA: if (r_hs && is_last) state_nxt = l2_axi_pkg::RD_IDLE;
            default:             state_nxt = l2_axi_pkg::RD_IDLE;
        endcase
    end

    // cache holds rd_req until rd_addr_ok, so ar is taken straight from it
    assign ar_valid   = (state == l2_axi_pkg::RD_ADDR);
    assign ar.addr    = rd_req.addr;
    assign ar.len     = rd_req.len;
    assign ar.size    = rd_req.size;
    assign ar.burst   = l2_axi_pkg::BURST_INCR;
    assign rd_addr_ok = ar_hs;
    assign r_ready    = (state == l2_axi_pkg::RD_DATA); // no cache back-pressure

    l2_axi_beat_counter #(
        .CNT_W (CNT_W)
    ) rd_cnt_i (
        .clk     (clk),
        .rstn    (rstn),
        .load    (ar_hs),
        .len     (burst_len),
        .beat    (r_hs),
        .is_last (is_last),
        .count   ()
    );

    l2_axi_rdata_path #(
        .FILL_WORD (FILL_WORD)
    ) rdata_i (
        .clk           (clk),
        .rstn          (rstn),
        .capture       (r_hs),
        .start         (ar_hs),
        .r             (r),
        .counted_last  (is_last),
        .rd_beat_valid (rd_beat_valid),
        .rd_beat       (rd_beat)
    );

    // relies on the cache keeping rd_req steady until rd_addr_ok
    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar)
    ) else $error("ar changed while waiting for ar_ready");

endmodule

// File: source/l2_axi_write_fsm.sv
/* write channel: latches the cache request into AW, streams the cache
   beats to W with a counted wlast, and reports completion on B */
`timescale 1ns/10ps

module l2_axi_write_fsm #(
    parameter int CNT_W = 8
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   wr_req_valid,
    input  l2_axi_pkg::burst_req_t wr_req,
    input  logic                   wr_data_valid,
    input  l2_axi_pkg::wr_beat_t   wr_data,
    input  logic                   aw_ready,
    input  logic                   w_ready,
    input  logic                   b_valid,
    input  l2_axi_pkg::axi_resp_e  b_resp,
    output logic                   wr_addr_ok,
    output logic                   wr_data_ready,
    output logic                   wr_done,
    output logic                   wr_err,
    output logic                   aw_valid,
    output l2_axi_pkg::axi_addr_t  aw,
    output logic                   w_valid,
    output l2_axi_pkg::axi_w_t     w,
    output logic                   b_ready
);

    l2_axi_pkg::wr_state_e  state;
    l2_axi_pkg::wr_state_e  state_nxt;
    l2_axi_pkg::burst_req_t aw_q;     // latched request
    logic                   in_data;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   is_last;
    logic [CNT_W-1:0]       burst_len;

    assign aw_hs     = aw_valid && aw_ready;
    assign w_hs      = w_valid && w_ready;
    assign in_data   = (state == l2_axi_pkg::WR_DATA);
    assign burst_len = CNT_W'(aw_q.len);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= l2_axi_pkg::WR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == l2_axi_pkg::WR_IDLE && wr_req_valid) begin
            aw_q <= wr_req;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            l2_axi_pkg::WR_IDLE: if (wr_req_valid) state_nxt = l2_axi_pkg::WR_ADDR;
            l2_axi_pkg::WR_ADDR: if (aw_ready) state_nxt = l2_axi_pkg::WR_DATA;
            l2_axi_pkg::WR_DATA: if (w_hs && is_last) state_nxt = l2_axi_pkg::WR_RESP;
            l2_axi_pkg::WR_RESP: if (b_valid) state_nxt = l2_axi_pkg::WR_IDLE;
            default:             state_nxt = l2_axi_pkg::WR_IDLE;
        endcase
    end

    assign aw_valid   = (state == l2_axi_pkg::WR_ADDR);
    assign aw.addr    = aw_q.addr;
    assign aw.len     = aw_q.len;
    assign aw.size    = aw_q.size;
    assign aw.burst   = l2_axi_pkg::BURST_INCR;
    assign wr_addr_ok = aw_hs;

    // beats pass straight through during the data phase
    assign w_valid       = in_data && wr_data_valid;
    assign wr_data_ready = in_data && w_ready;
    assign w.data        = wr_data.data;
    assign w.strb        = wr_data.strb;
    assign w.last        = is_last;

    assign b_ready = (state == l2_axi_pkg::WR_RESP);
    assign wr_done = b_ready && b_valid;
    assign wr_err  = wr_done && b_resp[1]; // SLVERR or DECERR

    l2_axi_beat_counter #(
        .CNT_W (CNT_W)
    ) wr_cnt_i (
        .clk     (clk),
        .rstn    (rstn),
        .load    (aw_hs),
        .len     (burst_len),
        .beat    (w_hs),
        .is_last (is_last),
        .count   ()
    );

    // slave may only answer once the whole burst has been sent
    a_b_after_last_w: assert property (
        @(posedge clk) disable iff (!rstn)
        b_valid |-> b_ready
    ) else $error("b_valid raised before the final W beat");

endmodule

// File: source/l2_axi_bridge.sv
/* top level of the L2 cache to AXI3 bridge; read and write channels run
   independently, each with one burst outstanding */
`timescale 1ns/10ps

module l2_axi_bridge #(
    parameter logic [31:0] FILL_WORD = 32'hABCD1234,
    parameter int          CNT_W     = 8
) (
    input  logic                   clk,
    input  logic                   rstn,

    // cache read side
    input  logic                   rd_req_valid,
    input  l2_axi_pkg::burst_req_t rd_req,
    output logic                   rd_addr_ok,
    output logic                   rd_beat_valid,
    output l2_axi_pkg::rd_beat_t   rd_beat,

    // cache write side
    input  logic                   wr_req_valid,
    input  l2_axi_pkg::burst_req_t wr_req,
    output logic                   wr_addr_ok,
    input  logic                   wr_data_valid,
    input  l2_axi_pkg::wr_beat_t   wr_data,
    output logic                   wr_data_ready,
    output logic                   wr_done,
    output logic                   wr_err,

    // AXI read
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output l2_axi_pkg::axi_addr_t  ar,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  l2_axi_pkg::axi_r_t     r,

    // AXI write
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output l2_axi_pkg::axi_addr_t  aw,
    output logic                   w_valid,
    input  logic                   w_ready,
    output l2_axi_pkg::axi_w_t     w,
    input  logic                   b_valid,
    output logic                   b_ready,
    input  l2_axi_pkg::axi_resp_e  b_resp
);

    l2_axi_read_fsm #(
        .FILL_WORD (FILL_WORD),
        .CNT_W     (CNT_W)
    ) rd_fsm_i (
        .clk           (clk),
        .rstn          (rstn),
        .rd_req_valid  (rd_req_valid),
        .rd_req        (rd_req),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r             (r),
        .rd_addr_ok    (rd_addr_ok),
        .ar_valid      (ar_valid),
        .ar            (ar),
        .r_ready       (r_ready),
        .rd_beat_valid (rd_beat_valid),
        .rd_beat       (rd_beat)
    );

    l2_axi_write_fsm #(
        .CNT_W (CNT_W)
    ) wr_fsm_i (
        .clk           (clk),
        .rstn          (rstn),
        .wr_req_valid  (wr_req_valid),
        .wr_req        (wr_req),
        .wr_data_valid (wr_data_valid),
        .wr_data       (wr_data),
        .aw_ready      (aw_ready),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .b_resp        (b_resp),
        .wr_addr_ok    (wr_addr_ok),
        .wr_data_ready (wr_data_ready),
        .wr_done       (wr_done),
        .wr_err        (wr_err),
        .aw_valid      (aw_valid),
        .aw            (aw),
        .w_valid       (w_valid),
        .w             (w),
        .b_ready       (b_ready)
    );

endmodule

// File: verification/axi_slave_model.sv
/* behavioral AXI3 slave for the bridge testbench; one burst per channel,
   random ready/valid delays, read data computed from the beat address */
`timescale 1ns/10ps

module axi_slave_model (
    input  logic                  clk,
    input  logic                  ar_valid,
    input  l2_axi_pkg::axi_addr_t ar,
    output logic                  ar_ready,
    output logic                  r_valid,
    input  logic                  r_ready,
    output l2_axi_pkg::axi_r_t    r,
    input  logic                  aw_valid,
    input  l2_axi_pkg::axi_addr_t aw,
    output logic                  aw_ready,
    input  logic                  w_valid,
    output logic                  w_ready,
    output logic                  b_valid,
    input  logic                  b_ready,
    output l2_axi_pkg::axi_resp_e b_resp,
    input  logic                  rd_err_on,    // per-burst error setup
    input  logic [7:0]            rd_err_beat,
    input  logic [1:0]            rd_err_resp,
    input  logic                  rd_early,
    input  l2_axi_pkg::axi_resp_e wr_bresp
);

    int seed = 97350;

    function automatic int next_delay();
        return $unsigned($random(seed)) % 4; // 0 to 3 cycles
    endfunction

    initial begin : read_side
        l2_axi_pkg::axi_addr_t req;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        forever begin
            @(negedge clk);
            if (ar_valid === 1'b1) begin
                repeat (next_delay()) @(negedge clk);
                ar_ready = 1'b1;
                @(posedge clk);
                req = ar;
                @(negedge clk);
                ar_ready = 1'b0;
                for (int i = 0; i <= int'(req.len); i++) begin
                    repeat (next_delay()) @(negedge clk);
                    r.data  = (req.addr + 32'(i) * 4) ^ 32'h5A5A_0000;
                    r.resp  = (rd_err_on && i == int'(rd_err_beat)) ? rd_err_resp : 2'b00;
                    r.last  = rd_early ? (i == int'(req.len) - 1) : (i == int'(req.len));
                    r_valid = 1'b1;
                    @(posedge clk);
                    while (r_ready !== 1'b1) @(posedge clk);
                    @(negedge clk);
                    r_valid = 1'b0;
                end
            end
        end
    end

    initial begin : write_side
        l2_axi_pkg::axi_addr_t req;
        int n;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        b_resp   = l2_axi_pkg::OKAY;
        forever begin
            @(negedge clk);
            if (aw_valid === 1'b1) begin
                repeat (next_delay()) @(negedge clk);
                aw_ready = 1'b1;
                @(posedge clk);
                req = aw;
                @(negedge clk);
                aw_ready = 1'b0;
                n = 0;
                while (n <= int'(req.len)) begin // count beats from aw.len, not wlast
                    repeat (next_delay()) @(negedge clk);
                    w_ready = 1'b1;
                    @(posedge clk);
                    if (w_valid === 1'b1) n++;
                    @(negedge clk);
                    w_ready = 1'b0;
                end
                repeat (next_delay()) @(negedge clk);
                b_resp  = wr_bresp;
                b_valid = 1'b1;
                @(posedge clk);
                while (b_ready !== 1'b1) @(posedge clk);
                @(negedge clk);
                b_valid = 1'b0;
            end
        end
    end

endmodule

// File: verification/l2_axi_bridge_tb.sv
/* testbench for the L2 cache to AXI3 bridge; runs a table of read and
   write bursts in pairs so both channels overlap against the slave model */
`timescale 1ns/10ps

module l2_axi_bridge_tb;

    localparam logic [31:0] FILL_WORD    = 32'hABCD1234;
    localparam int          NUM_ROWS     = 12;
    localparam int          RESET_CYCLES = 8;
    localparam int          CLK_PERIOD   = 8;

    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        logic [7:0]  len;
        logic        has_err;    // read beat err_beat carries resp
        logic [7:0]  err_beat;
        logic        early_last; // rlast one beat before the counted end
        logic [1:0]  resp;       // rresp of the errored beat, or bresp
    } test_row_t;

    logic clk = 1'b0;
    logic rstn;
    logic rd_req_valid, rd_addr_ok, rd_beat_valid;
    logic wr_req_valid, wr_addr_ok, wr_data_valid, wr_data_ready, wr_done, wr_err;
    logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready, w_valid, w_ready;
    logic b_valid, b_ready;
    l2_axi_pkg::burst_req_t rd_req, wr_req;
    l2_axi_pkg::rd_beat_t   rd_beat;
    l2_axi_pkg::wr_beat_t   wr_data;
    l2_axi_pkg::axi_addr_t  ar, aw, ar_q, aw_q;
    l2_axi_pkg::axi_r_t     r;
    l2_axi_pkg::axi_w_t     w, w_q;
    l2_axi_pkg::axi_resp_e  b_resp, wr_bresp;
    logic                   rd_err_on, rd_early;
    logic [7:0]             rd_err_beat;
    logic [1:0]             rd_err_resp;
    logic                   ar_stall = 1'b0, aw_stall = 1'b0, w_stall = 1'b0;
    int                     rd_beats_seen = 0, wr_done_seen = 0;
    test_row_t              rows [NUM_ROWS];

    l2_axi_bridge #(.FILL_WORD(FILL_WORD)) l2_axi_bridge_i (.*);
    axi_slave_model slave_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rd_beat(input l2_axi_pkg::rd_beat_t got, exp);
        if (got !== exp) begin
            $display("FAILED rd_beat: data %h last %h err %h, expected data %h last %h err %h",
                     got.data, got.last, got.err, exp.data, exp.last, exp.err);
            stop_run();
        end
    endtask

    task automatic check_w_beat(input l2_axi_pkg::axi_w_t got, exp);
        if (got !== exp) begin
            $display("FAILED w: data %h strb %h last %h, expected data %h strb %h last %h",
                     got.data, got.strb, got.last, exp.data, exp.strb, exp.last);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input l2_axi_pkg::axi_addr_t got, exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_done(input logic got, exp);
        if (got !== exp) begin
            $display("FAILED wr_err: got %h expected %h", got, exp);
            stop_run();
        end
    endtask

    // first errored beat is the slave error or the early rlast, whichever comes first
    function automatic l2_axi_pkg::rd_beat_t expect_rd(test_row_t row, int i);
        int   first_err;
        logic err;
        first_err = row.has_err ? int'(row.err_beat) : 256;
        if (row.early_last && int'(row.len) - 1 < first_err) first_err = int'(row.len) - 1;
        err = (i >= first_err);
        return {err ? FILL_WORD : (row.addr + 32'(i) * 4) ^ 32'h5A5A_0000,
                i == int'(row.len), err};
    endfunction

    function automatic l2_axi_pkg::wr_beat_t cache_beat(test_row_t row, int i);
        return {~row.addr + 32'(i) * 32'h0101_0101, i[0] ? 4'h3 : 4'hF};
    endfunction

    task automatic do_read(input test_row_t row);
        l2_axi_pkg::axi_addr_t exp_a;
        int i;
        exp_a        = {row.addr, row.len, 3'd2, l2_axi_pkg::BURST_INCR};
        rd_err_on    = row.has_err;
        rd_err_beat  = row.err_beat;
        rd_err_resp  = row.resp;
        rd_early     = row.early_last;
        rd_req       = {row.addr, row.len, 3'd2};
        rd_req_valid = 1'b1;
        @(posedge clk);
        while (!rd_addr_ok) @(posedge clk);
        check_addr("ar", ar, exp_a);
        @(negedge clk);
        rd_req_valid = 1'b0;
        i = 0;
        while (i <= int'(row.len)) begin
            @(posedge clk);
            if (rd_beat_valid) begin
                check_rd_beat(rd_beat, expect_rd(row, i));
                i++;
            end
        end
        @(negedge clk);
    endtask

    task automatic do_write(input test_row_t row);
        l2_axi_pkg::axi_addr_t exp_a;
        l2_axi_pkg::axi_w_t    exp_w;
        exp_a        = {row.addr, row.len, 3'd2, l2_axi_pkg::BURST_INCR};
        wr_bresp     = l2_axi_pkg::axi_resp_e'(row.resp);
        wr_req       = {row.addr, row.len, 3'd2};
        wr_req_valid = 1'b1;
        @(posedge clk);
        while (!wr_addr_ok) @(posedge clk);
        check_addr("aw", aw, exp_a);
        @(negedge clk);
        wr_req_valid = 1'b0;
        for (int i = 0; i <= int'(row.len); i++) begin
            wr_data       = cache_beat(row, i);
            wr_data_valid = 1'b1;
            @(posedge clk);
            while (!wr_data_ready) @(posedge clk);
            exp_w = {wr_data, i == int'(row.len)}; // wlast on the final beat only
            check_w_beat(w, exp_w);
            @(negedge clk);
        end
        wr_data_valid = 1'b0;
        @(posedge clk);
        while (!wr_done) @(posedge clk);
        check_done(wr_err, row.resp[1]);
        @(negedge clk);
    endtask

    task automatic run_row(input test_row_t row);
        if (row.is_write) do_write(row);
        else do_read(row);
    endtask

    // completion counts, and payloads held while valid waits for ready
    always @(posedge clk) begin
        if (!rstn) begin
            ar_stall <= 1'b0;
            aw_stall <= 1'b0;
            w_stall  <= 1'b0;
        end else begin
            if (rd_beat_valid) rd_beats_seen++;
            if (wr_done) wr_done_seen++;
            if ((ar_stall && {ar_valid, ar} !== {1'b1, ar_q}) ||
                (aw_stall && {aw_valid, aw} !== {1'b1, aw_q}) ||
                (w_stall && {w_valid, w} !== {1'b1, w_q})) begin
                $display("an AXI payload or valid changed while waiting for ready");
                stop_run();
            end
            ar_stall <= ar_valid && !ar_ready;
            aw_stall <= aw_valid && !aw_ready;
            w_stall  <= w_valid && !w_ready;
        end
        ar_q <= ar;
        aw_q <= aw;
        w_q  <= w;
    end

    initial begin : watchdog
        #((RESET_CYCLES + NUM_ROWS * 16 * 10) * CLK_PERIOD);
        $display("the run timed out before all bursts completed");
        stop_run();
    end

    initial begin : main
        logic [8:0] ctrl;
        int         exp_rd_beats;
        int         exp_wr_done;
        rstn          = 1'b0;
        rd_req_valid  = 1'b0;
        rd_req        = '0;
        wr_req_valid  = 1'b0;
        wr_req        = '0;
        wr_data_valid = 1'b0;
        wr_data       = '0;
        rd_err_on     = 1'b0;
        rd_err_beat   = '0;
        rd_err_resp   = '0;
        rd_early      = 1'b0;
        wr_bresp      = l2_axi_pkg::OKAY;
        exp_rd_beats  = 0;
        exp_wr_done   = 0;
        // read row then write row of each pair
        rows[0]  = {1'b0, 32'h0000_1000, 8'd3,  1'b0, 8'd0, 1'b0, 2'b00};
        rows[1]  = {1'b1, 32'h0000_2000, 8'd3,  1'b0, 8'd0, 1'b0, 2'b00};
        rows[2]  = {1'b0, 32'h0000_1100, 8'd3,  1'b1, 8'd2, 1'b0, 2'b10}; // SLVERR mid-burst
        rows[3]  = {1'b1, 32'h0000_2100, 8'd3,  1'b0, 8'd0, 1'b0, 2'b10};
        rows[4]  = {1'b0, 32'h0000_1200, 8'd5,  1'b0, 8'd0, 1'b1, 2'b00}; // early rlast
        rows[5]  = {1'b1, 32'h0000_2200, 8'd7,  1'b0, 8'd0, 1'b0, 2'b11};
        rows[6]  = {1'b0, 32'h0000_1300, 8'd7,  1'b1, 8'd0, 1'b0, 2'b11}; // DECERR on beat 0
        rows[7]  = {1'b1, 32'h0000_2300, 8'd15, 1'b0, 8'd0, 1'b0, 2'b00};
        rows[8]  = {1'b0, 32'h0000_1400, 8'd0,  1'b0, 8'd0, 1'b0, 2'b00};
        rows[9]  = {1'b1, 32'h0000_2400, 8'd0,  1'b0, 8'd0, 1'b0, 2'b00};
        rows[10] = {1'b0, 32'h0000_1404, 8'd0,  1'b0, 8'd0, 1'b0, 2'b00};
        rows[11] = {1'b1, 32'h0000_2404, 8'd0,  1'b0, 8'd0, 1'b0, 2'b10};
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        ctrl = {ar_valid, aw_valid, w_valid, r_ready, b_ready,
                rd_addr_ok, wr_addr_ok, rd_beat_valid, wr_done};
        if (ctrl !== '0) begin
            $display("FAILED control outputs after reset: got %h expected %h", ctrl, 9'h0);
            stop_run();
        end
        for (int k = 0; k < NUM_ROWS; k += 2) begin
            for (int j = k; j < k + 2; j++) begin
                if (rows[j].is_write) exp_wr_done++;
                else exp_rd_beats += int'(rows[j].len) + 1;
            end
            fork
                run_row(rows[k]);
                run_row(rows[k + 1]);
            join
        end
        repeat (4) @(negedge clk); // room for any stray beat
        if (rd_beats_seen == exp_rd_beats && wr_done_seen == exp_wr_done) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("saw %0d read beats of %0d and %0d write completions of %0d",
                     rd_beats_seen, exp_rd_beats, wr_done_seen, exp_wr_done);
            stop_run();
        end
    end

endmodule

// File: src.f
source/l2_axi_pkg.sv
source/l2_axi_beat_counter.sv
source/l2_axi_rdata_path.sv
source/l2_axi_read_fsm.sv
source/l2_axi_write_fsm.sv
source/l2_axi_bridge.sv
verification/axi_slave_model.sv
verification/l2_axi_bridge_tb.sv
